// ==== pad_pkg.sv ====
package pad_pkg;

   //////////////////////////////////////////////////////////////////////
   // sizes
   //////////////////////////////////////////////////////////////////////

   localparam int N_PADS      = 10;
   localparam int N_SPI_LINES = 4;

   // electrical config bits per pad
   localparam int PAD_CFG_W   = 6;
   localparam int PAD_FUNC_W  = 2;

   // write port, word is {func, cfg}
   localparam int PAD_ADDR_W  = 4;
   localparam int PAD_WDATA_W = PAD_FUNC_W + PAD_CFG_W;

   //////////////////////////////////////////////////////////////////////
   // function codes
   //////////////////////////////////////////////////////////////////////

   localparam logic [PAD_FUNC_W-1:0] FUNC_PERIPH = 2'd0;
   localparam logic [PAD_FUNC_W-1:0] FUNC_GPIO   = 2'd1;
   localparam logic [PAD_FUNC_W-1:0] FUNC_ALT    = 2'd2;
   localparam logic [PAD_FUNC_W-1:0] FUNC_EFPGA  = 2'd3;

   //////////////////////////////////////////////////////////////////////
   // pad indices
   //////////////////////////////////////////////////////////////////////

   // spi master data lines, line k sits on pad k
   localparam int PAD_SPIM_SDIO0 = 0;
   localparam int PAD_SPIM_SDIO1 = 1;
   localparam int PAD_SPIM_SDIO2 = 2;
   localparam int PAD_SPIM_SDIO3 = 3;
   localparam int PAD_SPIM_CSN0  = 4;
   localparam int PAD_SPIM_SCK   = 5;

   // uart
   localparam int PAD_UART_RX    = 6;
   localparam int PAD_UART_TX    = 7;

   // i2c0
   localparam int PAD_I2C0_SDA   = 8;
   localparam int PAD_I2C0_SCL   = 9;

endpackage

// ==== pad_cfg_regs.sv ====
`timescale 1ns/1ps

module pad_cfg_regs
   import pad_pkg::*;
(
   input  logic                                   clk_i,
   input  logic                                   reset_i,

   // register write port, always ready
   input  logic                                   cfg_we_i,
   input  logic [PAD_ADDR_W-1:0]                  cfg_addr_i,
   input  logic [PAD_WDATA_W-1:0]                 cfg_wdata_i,

   output logic [N_PADS-1:0][PAD_FUNC_W-1:0]      pad_func_o,
   output logic [N_PADS-1:0][PAD_CFG_W-1:0]       pad_cfg_o
);

   logic [N_PADS-1:0][PAD_FUNC_W-1:0] func_q;
   logic [N_PADS-1:0][PAD_CFG_W-1:0]  cfg_q;

   logic [PAD_FUNC_W-1:0] wr_func;
   logic [PAD_CFG_W-1:0]  wr_cfg;
   logic                  wr_valid;

   // function in the top bits, electrical config below
   assign wr_func  = cfg_wdata_i[PAD_WDATA_W-1 -: PAD_FUNC_W];
   assign wr_cfg   = cfg_wdata_i[PAD_CFG_W-1:0];

   // addresses past the last pad are dropped
   assign wr_valid = cfg_we_i && (cfg_addr_i < PAD_ADDR_W'(N_PADS));

   //////////////////////////////////////////////////////////////////////
   // per-pad storage
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         // every pad comes up on its dedicated peripheral
         func_q <= {N_PADS{FUNC_PERIPH}};
         cfg_q  <= '0;
      end else if (wr_valid) begin
         func_q[cfg_addr_i] <= wr_func;
         cfg_q[cfg_addr_i]  <= wr_cfg;
      end
   end

   assign pad_func_o = func_q;
   assign pad_cfg_o  = cfg_q;

   // software only ever addresses pads that exist
   wr_addr_in_range: assert property (
      @(posedge clk_i) disable iff (reset_i)
      cfg_we_i |-> (cfg_addr_i < PAD_ADDR_W'(N_PADS))
   ) else $error("pad config write to address %0d beyond last pad", cfg_addr_i);

endmodule

// ==== pad_out_mux.sv ====
`timescale 1ns/1ps

module pad_out_mux
   import pad_pkg::*;
(
   input  logic [N_PADS-1:0][PAD_FUNC_W-1:0] pad_func_i,
   input  logic [N_PADS-1:0][PAD_CFG_W-1:0]  pad_cfg_i,

   // spi master
   input  logic [N_SPI_LINES-1:0]            spi_sdo_i,
   input  logic [N_SPI_LINES-1:0]            spi_oen_i,
   input  logic                              spi_csn_i,
   input  logic                              spi_clk_i,

   // uart
   input  logic                              uart_tx_i,

   // i2c0 on its own pads
   input  logic                              i2c0_sda_out_i,
   input  logic                              i2c0_sda_oe_i,
   input  logic                              i2c0_scl_out_i,
   input  logic                              i2c0_scl_oe_i,

   // i2c1 as alternate function
   input  logic                              i2c1_sda_out_i,
   input  logic                              i2c1_sda_oe_i,
   input  logic                              i2c1_scl_out_i,
   input  logic                              i2c1_scl_oe_i,

   // gpio
   input  logic [N_PADS-1:0]                 gpio_out_i,
   input  logic [N_PADS-1:0]                 gpio_dir_i,
   input  logic [N_PADS-1:0][PAD_CFG_W-1:0]  gpio_cfg_i,

   // pad frame side
   output logic [N_PADS-1:0]                 pad_out_o,
   output logic [N_PADS-1:0]                 pad_oe_o,
   output logic [N_PADS-1:0][PAD_CFG_W-1:0]  pad_cfg_o
);

   logic [N_PADS-1:0] periph_out;
   logic [N_PADS-1:0] periph_oe;
   logic [N_PADS-1:0] alt_out;
   logic [N_PADS-1:0] alt_oe;

   //////////////////////////////////////////////////////////////////////
   // function 0 drives the dedicated peripherals
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      periph_out = '0;
      periph_oe  = '0;
      // spi oen is active low
      for (int k = 0; k < N_SPI_LINES; k++) begin
         periph_out[PAD_SPIM_SDIO0 + k] = spi_sdo_i[k];
         periph_oe[PAD_SPIM_SDIO0 + k]  = ~spi_oen_i[k];
      end
      periph_out[PAD_SPIM_CSN0] = spi_csn_i;
      periph_oe[PAD_SPIM_CSN0]  = 1'b1;
      periph_out[PAD_SPIM_SCK]  = spi_clk_i;
      periph_oe[PAD_SPIM_SCK]   = 1'b1;
      // rx is input only and stays at 0/0 from the default above
      periph_out[PAD_UART_TX]   = uart_tx_i;
      periph_oe[PAD_UART_TX]    = 1'b1;
      periph_out[PAD_I2C0_SDA]  = i2c0_sda_out_i;
      periph_oe[PAD_I2C0_SDA]   = i2c0_sda_oe_i;
      periph_out[PAD_I2C0_SCL]  = i2c0_scl_out_i;
      periph_oe[PAD_I2C0_SCL]   = i2c0_scl_oe_i;
   end

   // function 2 puts i2c1 on sdio2/3 or on the uart pair
   always_comb begin
      alt_out = '0;
      alt_oe  = '0;
      alt_out[PAD_SPIM_SDIO2] = i2c1_sda_out_i;
      alt_oe[PAD_SPIM_SDIO2]  = i2c1_sda_oe_i;
      alt_out[PAD_UART_RX]    = i2c1_sda_out_i;
      alt_oe[PAD_UART_RX]     = i2c1_sda_oe_i;
      alt_out[PAD_SPIM_SDIO3] = i2c1_scl_out_i;
      alt_oe[PAD_SPIM_SDIO3]  = i2c1_scl_oe_i;
      alt_out[PAD_UART_TX]    = i2c1_scl_out_i;
      alt_oe[PAD_UART_TX]     = i2c1_scl_oe_i;
   end

   //////////////////////////////////////////////////////////////////////
   // per-pad select
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         case (pad_func_i[p])
            FUNC_PERIPH: begin
               pad_out_o[p] = periph_out[p];
               pad_oe_o[p]  = periph_oe[p];
            end
            FUNC_GPIO: begin
               pad_out_o[p] = gpio_out_i[p];
               pad_oe_o[p]  = gpio_dir_i[p];
            end
            FUNC_ALT: begin
               pad_out_o[p] = alt_out[p];
               pad_oe_o[p]  = alt_oe[p];
            end
            // efpga only captures and never drives the pad
            default: begin
               pad_out_o[p] = 1'b0;
               pad_oe_o[p]  = 1'b0;
            end
         endcase
         // gpio brings its own electrical setting
         pad_cfg_o[p] = (pad_func_i[p] == FUNC_GPIO) ? gpio_cfg_i[p] : pad_cfg_i[p];
      end
   end

endmodule

// ==== pad_in_demux.sv ====
`timescale 1ns/1ps

module pad_in_demux
   import pad_pkg::*;
(
   input  logic [N_PADS-1:0][PAD_FUNC_W-1:0] pad_func_i,
   input  logic [N_PADS-1:0]                 pad_in_i,

   // spi master
   output logic [N_SPI_LINES-1:0]            spi_sdi_o,

   // uart
   output logic                              uart_rx_o,

   // i2c0 and i2c1
   output logic                              i2c0_sda_in_o,
   output logic                              i2c0_scl_in_o,
   output logic                              i2c1_sda_in_o,
   output logic                              i2c1_scl_in_o,

   // gpio and efpga capture
   output logic [N_PADS-1:0]                 gpio_in_o,
   output logic [N_PADS-1:0]                 fpga_in_o
);

   logic [N_PADS-1:0] is_periph;
   logic [N_PADS-1:0] is_gpio;
   logic [N_PADS-1:0] is_alt;
   logic [N_PADS-1:0] is_efpga;

   // one-hot view of each pad's function
   always_comb begin
      for (int p = 0; p < N_PADS; p++) begin
         is_periph[p] = (pad_func_i[p] == FUNC_PERIPH);
         is_gpio[p]   = (pad_func_i[p] == FUNC_GPIO);
         is_alt[p]    = (pad_func_i[p] == FUNC_ALT);
         is_efpga[p]  = (pad_func_i[p] == FUNC_EFPGA);
      end
   end

   //////////////////////////////////////////////////////////////////////
   // peripheral inputs
   //////////////////////////////////////////////////////////////////////

   // spi reads its own sdio pads and idles low
   always_comb begin
      for (int k = 0; k < N_SPI_LINES; k++) begin
         spi_sdi_o[k] = is_periph[PAD_SPIM_SDIO0 + k] ? pad_in_i[PAD_SPIM_SDIO0 + k] : 1'b0;
      end
   end

   // uart and i2c idle high when the pad is taken elsewhere
   assign uart_rx_o     = is_periph[PAD_UART_RX]  ? pad_in_i[PAD_UART_RX]  : 1'b1;
   assign i2c0_sda_in_o = is_periph[PAD_I2C0_SDA] ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
   assign i2c0_scl_in_o = is_periph[PAD_I2C0_SCL] ? pad_in_i[PAD_I2C0_SCL] : 1'b1;

   // for i2c1 the sdio pads win over the uart pads
   assign i2c1_sda_in_o = is_alt[PAD_SPIM_SDIO2] ? pad_in_i[PAD_SPIM_SDIO2] :
                          is_alt[PAD_UART_RX]    ? pad_in_i[PAD_UART_RX]    : 1'b1;
   assign i2c1_scl_in_o = is_alt[PAD_SPIM_SDIO3] ? pad_in_i[PAD_SPIM_SDIO3] :
                          is_alt[PAD_UART_TX]    ? pad_in_i[PAD_UART_TX]    : 1'b1;

   //////////////////////////////////////////////////////////////////////
   // gpio and efpga
   //////////////////////////////////////////////////////////////////////

   assign gpio_in_o = pad_in_i & is_gpio;
   assign fpga_in_o = pad_in_i & is_efpga;

endmodule

// ==== pad_control.sv ====
`timescale 1ns/1ps

module pad_control
   import pad_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              reset_i,

   // config register write port
   input  logic                              cfg_we_i,
   input  logic [PAD_ADDR_W-1:0]             cfg_addr_i,
   input  logic [PAD_WDATA_W-1:0]            cfg_wdata_i,

   // spi master
   input  logic [N_SPI_LINES-1:0]            spi_sdo_i,
   input  logic [N_SPI_LINES-1:0]            spi_oen_i,
   input  logic                              spi_csn_i,
   input  logic                              spi_clk_i,
   output logic [N_SPI_LINES-1:0]            spi_sdi_o,

   // uart
   input  logic                              uart_tx_i,
   output logic                              uart_rx_o,

   // i2c0
   input  logic                              i2c0_sda_out_i,
   input  logic                              i2c0_sda_oe_i,
   input  logic                              i2c0_scl_out_i,
   input  logic                              i2c0_scl_oe_i,
   output logic                              i2c0_sda_in_o,
   output logic                              i2c0_scl_in_o,

   // i2c1
   input  logic                              i2c1_sda_out_i,
   input  logic                              i2c1_sda_oe_i,
   input  logic                              i2c1_scl_out_i,
   input  logic                              i2c1_scl_oe_i,
   output logic                              i2c1_sda_in_o,
   output logic                              i2c1_scl_in_o,

   // gpio
   input  logic [N_PADS-1:0]                 gpio_out_i,
   input  logic [N_PADS-1:0]                 gpio_dir_i,
   input  logic [N_PADS-1:0][PAD_CFG_W-1:0]  gpio_cfg_i,
   output logic [N_PADS-1:0]                 gpio_in_o,

   // efpga capture
   output logic [N_PADS-1:0]                 fpga_in_o,

   // pad frame
   input  logic [N_PADS-1:0]                 pad_in_i,
   output logic [N_PADS-1:0]                 pad_out_o,
   output logic [N_PADS-1:0]                 pad_oe_o,
   output logic [N_PADS-1:0][PAD_CFG_W-1:0]  pad_cfg_o
);

   logic [N_PADS-1:0][PAD_FUNC_W-1:0] pad_func;
   logic [N_PADS-1:0][PAD_CFG_W-1:0]  pad_cfg;

   pad_cfg_regs i_cfg_regs (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .pad_func_o  (pad_func),
      .pad_cfg_o   (pad_cfg)
   );

   pad_out_mux i_out_mux (
      .pad_func_i     (pad_func),
      .pad_cfg_i      (pad_cfg),
      .spi_sdo_i      (spi_sdo_i),
      .spi_oen_i      (spi_oen_i),
      .spi_csn_i      (spi_csn_i),
      .spi_clk_i      (spi_clk_i),
      .uart_tx_i      (uart_tx_i),
      .i2c0_sda_out_i (i2c0_sda_out_i),
      .i2c0_sda_oe_i  (i2c0_sda_oe_i),
      .i2c0_scl_out_i (i2c0_scl_out_i),
      .i2c0_scl_oe_i  (i2c0_scl_oe_i),
      .i2c1_sda_out_i (i2c1_sda_out_i),
      .i2c1_sda_oe_i  (i2c1_sda_oe_i),
      .i2c1_scl_out_i (i2c1_scl_out_i),
      .i2c1_scl_oe_i  (i2c1_scl_oe_i),
      .gpio_out_i     (gpio_out_i),
      .gpio_dir_i     (gpio_dir_i),
      .gpio_cfg_i     (gpio_cfg_i),
      .pad_out_o      (pad_out_o),
      .pad_oe_o       (pad_oe_o),
      .pad_cfg_o      (pad_cfg_o)
   );

   pad_in_demux i_in_demux (
      .pad_func_i    (pad_func),
      .pad_in_i      (pad_in_i),
      .spi_sdi_o     (spi_sdi_o),
      .uart_rx_o     (uart_rx_o),
      .i2c0_sda_in_o (i2c0_sda_in_o),
      .i2c0_scl_in_o (i2c0_scl_in_o),
      .i2c1_sda_in_o (i2c1_sda_in_o),
      .i2c1_scl_in_o (i2c1_scl_in_o),
      .gpio_in_o     (gpio_in_o),
      .fpga_in_o     (fpga_in_o)
   );

endmodule

// ==== pad_checker.sv ====
`timescale 1ns/1ps

module pad_checker
   import pad_pkg::*;
(
   input  logic                                              clk_i,
   input  logic                                              reset_i,
   input  logic [2:0]                                        phase_i,

   // reference outputs, packed the same way as in tb_pad_control
   input  logic [N_SPI_LINES+5+N_PADS*(4+PAD_CFG_W)-1:0]     exp_i,

   // dut outputs
   input  logic [N_SPI_LINES-1:0]                            spi_sdi_i,
   input  logic                                              uart_rx_i,
   input  logic                                              i2c0_sda_in_i,
   input  logic                                              i2c0_scl_in_i,
   input  logic                                              i2c1_sda_in_i,
   input  logic                                              i2c1_scl_in_i,
   input  logic [N_PADS-1:0]                                 gpio_in_i,
   input  logic [N_PADS-1:0]                                 fpga_in_i,
   input  logic [N_PADS-1:0]                                 pad_out_i,
   input  logic [N_PADS-1:0]                                 pad_oe_i,
   input  logic [N_PADS-1:0][PAD_CFG_W-1:0]                  pad_cfg_i,

   output int                                                n_checks_o,
   output int                                                n_errors_o,
   output logic                                              timeout_o
);

   // reset, directed phases and 200 random cycles come to about 290
   localparam int MAX_CYCLES = 400;

   // field offsets inside exp_i
   localparam int O_URX  = N_SPI_LINES;
   localparam int O_SDA0 = O_URX + 1;
   localparam int O_SCL0 = O_URX + 2;
   localparam int O_SDA1 = O_URX + 3;
   localparam int O_SCL1 = O_URX + 4;
   localparam int O_GIN  = O_URX + 5;
   localparam int O_FIN  = O_GIN + N_PADS;
   localparam int O_POUT = O_FIN + N_PADS;
   localparam int O_POE  = O_POUT + N_PADS;
   localparam int O_PCFG = O_POE + N_PADS;

   int   n_checks  = 0;
   int   n_errors  = 0;
   int   cycles    = 0;
   logic timed_out = 1'b0;

   assign n_checks_o = n_checks;
   assign n_errors_o = n_errors;
   assign timeout_o  = timed_out;

   function automatic string phase_name(input logic [2:0] ph);
      case (ph)
         3'd0:    return "reset_defaults";
         3'd1:    return "gpio";
         3'd2:    return "alt_i2c1";
         3'd3:    return "efpga_capture";
         3'd4:    return "random_mix";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_field(input string field, input logic [63:0] exp,
                              input logic [63:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("CHECK FAILED %s %s: expected %h actual %h",
                  phase_name(phase_i), field, exp, act);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // compare, mid-cycle once drive and register update have settled
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk_i) begin
      if (!reset_i) begin
         check_field("spi_sdi_o", 64'(exp_i[N_SPI_LINES-1:0]), 64'(spi_sdi_i));
         check_field("uart_rx_o", 64'(exp_i[O_URX]), 64'(uart_rx_i));
         check_field("i2c0_sda_in_o", 64'(exp_i[O_SDA0]), 64'(i2c0_sda_in_i));
         check_field("i2c0_scl_in_o", 64'(exp_i[O_SCL0]), 64'(i2c0_scl_in_i));
         check_field("i2c1_sda_in_o", 64'(exp_i[O_SDA1]), 64'(i2c1_sda_in_i));
         check_field("i2c1_scl_in_o", 64'(exp_i[O_SCL1]), 64'(i2c1_scl_in_i));
         check_field("gpio_in_o", 64'(exp_i[O_GIN +: N_PADS]), 64'(gpio_in_i));
         check_field("fpga_in_o", 64'(exp_i[O_FIN +: N_PADS]), 64'(fpga_in_i));
         check_field("pad_out_o", 64'(exp_i[O_POUT +: N_PADS]), 64'(pad_out_i));
         check_field("pad_oe_o", 64'(exp_i[O_POE +: N_PADS]), 64'(pad_oe_i));
         check_field("pad_cfg_o", 64'(exp_i[O_PCFG +: N_PADS*PAD_CFG_W]), 64'(pad_cfg_i));
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES && !timed_out) begin
         $display("timeout: test did not finish within %0d cycles", MAX_CYCLES);
         timed_out <= 1'b1;
      end
   end

endmodule

// ==== tb_pad_control.sv ====
`timescale 1ns/1ps

module tb_pad_control
   import pad_pkg::*;
();

   localparam int RESET_CYCLES = 8;
   localparam int RAND_CYCLES  = 200;
   localparam int EXP_W        = N_SPI_LINES + 5 + N_PADS * (4 + PAD_CFG_W);

   // dut inputs, named after the ports
   logic                             clk_i          = 1'b0;
   logic                             reset_i        = 1'b1;
   logic                             cfg_we_i       = 1'b0;
   logic [PAD_ADDR_W-1:0]            cfg_addr_i     = '0;
   logic [PAD_WDATA_W-1:0]           cfg_wdata_i    = '0;
   logic [N_SPI_LINES-1:0]           spi_sdo_i      = '0;
   logic [N_SPI_LINES-1:0]           spi_oen_i      = '1;
   logic                             spi_csn_i      = 1'b1;
   logic                             spi_clk_i      = 1'b0;
   logic                             uart_tx_i      = 1'b1;
   logic                             i2c0_sda_out_i = 1'b0;
   logic                             i2c0_sda_oe_i  = 1'b0;
   logic                             i2c0_scl_out_i = 1'b0;
   logic                             i2c0_scl_oe_i  = 1'b0;
   logic                             i2c1_sda_out_i = 1'b0;
   logic                             i2c1_sda_oe_i  = 1'b0;
   logic                             i2c1_scl_out_i = 1'b0;
   logic                             i2c1_scl_oe_i  = 1'b0;
   logic [N_PADS-1:0]                gpio_out_i     = '0;
   logic [N_PADS-1:0]                gpio_dir_i     = '0;
   logic [N_PADS-1:0][PAD_CFG_W-1:0] gpio_cfg_i     = '0;
   logic [N_PADS-1:0]                pad_in_i       = '0;

   // dut outputs
   logic [N_SPI_LINES-1:0]           spi_sdi_o;
   logic                             uart_rx_o;
   logic                             i2c0_sda_in_o;
   logic                             i2c0_scl_in_o;
   logic                             i2c1_sda_in_o;
   logic                             i2c1_scl_in_o;
   logic [N_PADS-1:0]                gpio_in_o;
   logic [N_PADS-1:0]                fpga_in_o;
   logic [N_PADS-1:0]                pad_out_o;
   logic [N_PADS-1:0]                pad_oe_o;
   logic [N_PADS-1:0][PAD_CFG_W-1:0] pad_cfg_o;

   // register model, reference and run state
   logic [N_PADS-1:0][PAD_FUNC_W-1:0] model_func;
   logic [N_PADS-1:0][PAD_CFG_W-1:0]  model_cfg;
   logic [EXP_W-1:0]                  expected;
   logic [31:0]                       rng_state = 32'd82;
   logic [2:0]                        phase     = 3'd0;
   int                                n_checks;
   int                                n_errors;
   logic                              timed_out;

   always #50 clk_i = ~clk_i;

   pad_control i_dut (.*);

   pad_checker i_checker (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .phase_i       (phase),
      .exp_i         (expected),
      .spi_sdi_i     (spi_sdi_o),
      .uart_rx_i     (uart_rx_o),
      .i2c0_sda_in_i (i2c0_sda_in_o),
      .i2c0_scl_in_i (i2c0_scl_in_o),
      .i2c1_sda_in_i (i2c1_sda_in_o),
      .i2c1_scl_in_i (i2c1_scl_in_o),
      .gpio_in_i     (gpio_in_o),
      .fpga_in_i     (fpga_in_o),
      .pad_out_i     (pad_out_o),
      .pad_oe_i      (pad_oe_o),
      .pad_cfg_i     (pad_cfg_o),
      .n_checks_o    (n_checks),
      .n_errors_o    (n_errors),
      .timeout_o     (timed_out)
   );

   //////////////////////////////////////////////////////////////////////
   // register model and reference
   //////////////////////////////////////////////////////////////////////

   // a write seen at an edge shows up in the following cycle
   always @(posedge clk_i) begin
      if (reset_i) begin
         model_func <= {N_PADS{FUNC_PERIPH}};
         model_cfg  <= '0;
      end else if (cfg_we_i && (cfg_addr_i < PAD_ADDR_W'(N_PADS))) begin
         model_func[cfg_addr_i] <= cfg_wdata_i[PAD_WDATA_W-1 -: PAD_FUNC_W];
         model_cfg[cfg_addr_i]  <= cfg_wdata_i[PAD_CFG_W-1:0];
      end
   end

   // packed as {cfg, oe, out, fpga_in, gpio_in, i2c1 scl/sda, i2c0 scl/sda, uart rx, spi sdi}
   function automatic logic [EXP_W-1:0] expected_outputs(
      input logic [N_PADS-1:0][PAD_FUNC_W-1:0] fn,
      input logic [N_PADS-1:0][PAD_CFG_W-1:0]  cf
   );
      logic [N_PADS-1:0]                per_out;
      logic [N_PADS-1:0]                per_oe;
      logic [N_PADS-1:0]                alt_out;
      logic [N_PADS-1:0]                alt_oe;
      logic [N_PADS-1:0]                pout;
      logic [N_PADS-1:0]                poe;
      logic [N_PADS-1:0]                gin;
      logic [N_PADS-1:0]                fin;
      logic [N_PADS-1:0][PAD_CFG_W-1:0] pcfg;
      logic [N_SPI_LINES-1:0]           sdi;
      logic                             urx;
      logic                             sda0;
      logic                             scl0;
      logic                             sda1;
      logic                             scl1;
      // drive tables, pad 9 on the left
      per_out = {i2c0_scl_out_i, i2c0_sda_out_i, uart_tx_i, 1'b0, spi_clk_i, spi_csn_i,
                 spi_sdo_i};
      per_oe  = {i2c0_scl_oe_i, i2c0_sda_oe_i, 1'b1, 1'b0, 1'b1, 1'b1, ~spi_oen_i};
      alt_out = {2'b00, i2c1_scl_out_i, i2c1_sda_out_i, 2'b00, i2c1_scl_out_i,
                 i2c1_sda_out_i, 2'b00};
      alt_oe  = {2'b00, i2c1_scl_oe_i, i2c1_sda_oe_i, 2'b00, i2c1_scl_oe_i,
                 i2c1_sda_oe_i, 2'b00};
      for (int p = 0; p < N_PADS; p++) begin
         pout[p] = (fn[p] == FUNC_PERIPH) ? per_out[p] :
                   (fn[p] == FUNC_GPIO)   ? gpio_out_i[p] :
                   (fn[p] == FUNC_ALT)    ? alt_out[p] : 1'b0;
         poe[p]  = (fn[p] == FUNC_PERIPH) ? per_oe[p] :
                   (fn[p] == FUNC_GPIO)   ? gpio_dir_i[p] :
                   (fn[p] == FUNC_ALT)    ? alt_oe[p] : 1'b0;
         pcfg[p] = (fn[p] == FUNC_GPIO) ? gpio_cfg_i[p] : cf[p];
         gin[p]  = (fn[p] == FUNC_GPIO) && pad_in_i[p];
         fin[p]  = (fn[p] == FUNC_EFPGA) && pad_in_i[p];
      end
      for (int k = 0; k < N_SPI_LINES; k++) begin
         sdi[k] = (fn[PAD_SPIM_SDIO0 + k] == FUNC_PERIPH) ? pad_in_i[PAD_SPIM_SDIO0 + k] : 1'b0;
      end
      urx  = (fn[PAD_UART_RX] == FUNC_PERIPH) ? pad_in_i[PAD_UART_RX] : 1'b1;
      sda0 = (fn[PAD_I2C0_SDA] == FUNC_PERIPH) ? pad_in_i[PAD_I2C0_SDA] : 1'b1;
      scl0 = (fn[PAD_I2C0_SCL] == FUNC_PERIPH) ? pad_in_i[PAD_I2C0_SCL] : 1'b1;
      // sdio2/3 take priority over the uart pair
      sda1 = (fn[PAD_SPIM_SDIO2] == FUNC_ALT) ? pad_in_i[PAD_SPIM_SDIO2] :
             (fn[PAD_UART_RX] == FUNC_ALT)    ? pad_in_i[PAD_UART_RX]    : 1'b1;
      scl1 = (fn[PAD_SPIM_SDIO3] == FUNC_ALT) ? pad_in_i[PAD_SPIM_SDIO3] :
             (fn[PAD_UART_TX] == FUNC_ALT)    ? pad_in_i[PAD_UART_TX]    : 1'b1;
      return {pcfg, poe, pout, fin, gin, scl1, sda1, scl0, sda0, urx, sdi};
   endfunction

   always_comb expected = expected_outputs(model_func, model_cfg);

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   task automatic drive_random_inputs();
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      r0 = next_random();
      r1 = next_random();
      r2 = next_random();
      r3 = next_random();
      spi_sdo_i      <= r0[3:0];
      spi_oen_i      <= r0[7:4];
      spi_csn_i      <= r0[8];
      spi_clk_i      <= r0[9];
      uart_tx_i      <= r0[10];
      i2c0_sda_out_i <= r0[11];
      i2c0_sda_oe_i  <= r0[12];
      i2c0_scl_out_i <= r0[13];
      i2c0_scl_oe_i  <= r0[14];
      i2c1_sda_out_i <= r0[15];
      i2c1_sda_oe_i  <= r0[16];
      i2c1_scl_out_i <= r0[17];
      i2c1_scl_oe_i  <= r0[18];
      gpio_out_i     <= r1[9:0];
      gpio_dir_i     <= r1[19:10];
      pad_in_i       <= r1[29:20];
      gpio_cfg_i     <= {r2, r3[27:0]};
   endtask

   task automatic idle_cycle();
      @(posedge clk_i);
      drive_random_inputs();
      cfg_we_i <= 1'b0;
   endtask

   task automatic write_pad(input int pad, input logic [PAD_FUNC_W-1:0] func);
      logic [31:0] r;
      @(posedge clk_i);
      drive_random_inputs();
      r = next_random();
      cfg_we_i    <= 1'b1;
      cfg_addr_i  <= PAD_ADDR_W'(pad);
      cfg_wdata_i <= {func, r[PAD_CFG_W-1:0]};
   endtask

   task automatic set_all_pads(input logic [PAD_FUNC_W-1:0] func);
      for (int p = 0; p < N_PADS; p++) begin
         write_pad(p, func);
      end
   endtask

   task automatic random_cycle();
      logic [31:0] r;
      @(posedge clk_i);
      drive_random_inputs();
      r = next_random();
      cfg_we_i    <= r[0];
      cfg_addr_i  <= PAD_ADDR_W'(r[31:16] % N_PADS);
      cfg_wdata_i <= r[15:8];
   endtask

   initial begin
      repeat (RESET_CYCLES) @(posedge clk_i);
      reset_i <= 1'b0;
      // reset defaults while the pads keep toggling
      repeat (4) idle_cycle();
      phase <= 3'd1;
      for (int p = 0; p < N_PADS; p++) begin
         write_pad(p, FUNC_GPIO);
         idle_cycle();
      end
      // i2c1 on the uart pair first, then sdio2/3 on top of it
      phase <= 3'd2;
      set_all_pads(FUNC_PERIPH);
      write_pad(PAD_UART_RX, FUNC_ALT);
      write_pad(PAD_UART_TX, FUNC_ALT);
      repeat (2) idle_cycle();
      write_pad(PAD_SPIM_SDIO2, FUNC_ALT);
      write_pad(PAD_SPIM_SDIO3, FUNC_ALT);
      repeat (2) idle_cycle();
      write_pad(PAD_UART_RX, FUNC_PERIPH);
      write_pad(PAD_UART_TX, FUNC_PERIPH);
      repeat (2) idle_cycle();
      // pads with no alternate function drive 0/0
      set_all_pads(FUNC_ALT);
      repeat (2) idle_cycle();
      phase <= 3'd3;
      for (int p = 0; p < N_PADS; p++) begin
         write_pad(p, FUNC_EFPGA);
         idle_cycle();
      end
      phase <= 3'd4;
      repeat (RAND_CYCLES) random_cycle();
      repeat (2) idle_cycle();
      $display("pad mux checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0 && n_checks > 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   always @(posedge clk_i) begin
      if (timed_out) begin
         $display("pad mux checks: %0d, errors: %0d", n_checks, n_errors);
         $display("FAIL: see errors above");
         $finish;
      end
   end

endmodule

// ==== tb.f ====
pad_pkg.sv
pad_cfg_regs.sv
pad_out_mux.sv
pad_in_demux.sv
pad_control.sv
pad_checker.sv
tb_pad_control.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_pad_control
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
